//--- src/code_pkg.sv
`default_nettype none

package code_pkg;

    localparam int K = 3;           // constraint length
    localparam int NUM_STATES = 4;

    localparam logic [K-1:0] G0 = 3'o7;  // msb taps the newest bit
    localparam logic [K-1:0] G1 = 3'o5;

    typedef logic [1:0] sym_t;                   // {g0, g1}
    typedef logic [K-2:0] tstate_t;              // {u[k-1], u[k-2]}
    typedef logic [4:0] metric_t;
    typedef logic [NUM_STATES-1:0] decision_t;   // 1 = odd predecessor won

    // bits holds the new input bit above the two previous ones
    function automatic sym_t encode_sym(logic [K-1:0] bits);
        return {^(bits & G0), ^(bits & G1)};
    endfunction

    // state before a transition, from the state after it and the survivor bit
    function automatic tstate_t pred_state(tstate_t ns, logic lsb);
        return tstate_t'({ns, lsb});
    endfunction

endpackage

`default_nettype wire

//--- src/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef logic mode_t;

    localparam mode_t ENCODE_MODE = 1'b0;
    localparam mode_t DECODE_MODE = 1'b1;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_ENCODE,
        ST_SLICE,
        ST_METRIC,
        ST_TRELLIS,
        ST_FLUSH,
        ST_MEM_WAIT,
        ST_TRACE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/codec_control.sv
`timescale 1ns/10ps
`default_nettype none

module codec_control #(
    parameter int MEM_WAIT = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_en,
    input  ctrl_pkg::mode_t i_mode,
    input  logic            i_sync,
    output logic            o_en_ce,
    output logic            o_en_s,
    output logic            o_en_bm,
    output logic            o_en_acs,
    output logic            o_en_m,
    output logic            o_en_t
);

    import ctrl_pkg::*;

    localparam int CW = $clog2(MEM_WAIT + 1);

    ctrl_state_t state;
    ctrl_state_t nxt_state;
    logic [CW-1:0] wait_cnt;
    logic [5:0] en_vec;  // ce, s, bm, acs, m, t

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en)
        begin
            state <= ST_RESET;
            wait_cnt <= '0;
        end
        else
        begin
            state <= nxt_state;
            if (state == ST_MEM_WAIT)
                wait_cnt <= wait_cnt + 1'b1;
            else
                wait_cnt <= '0;
        end
    end

    always_comb
    begin
        nxt_state = state;
        en_vec = 6'b000000;
        case (state)
            ST_RESET:
                nxt_state = (i_mode == DECODE_MODE) ? ST_SLICE : ST_ENCODE;
            ST_ENCODE:
                en_vec = 6'b100000;
            ST_SLICE:
            begin
                en_vec = 6'b110000;  // first symbol on the input now
                nxt_state = ST_METRIC;
            end
            ST_METRIC:
            begin
                en_vec = 6'b111000;
                nxt_state = ST_TRELLIS;
            end
            ST_TRELLIS:
            begin
                en_vec = 6'b111110;
                if (i_sync)
                    nxt_state = ST_FLUSH;
            end
            ST_FLUSH:
            begin
                en_vec = 6'b000110;
                nxt_state = ST_MEM_WAIT;
            end
            ST_MEM_WAIT:
            begin
                en_vec = 6'b000010;
                if (wait_cnt == CW'(MEM_WAIT - 1))
                    nxt_state = ST_TRACE;
            end
            ST_TRACE:
                en_vec = 6'b000011;
            default:
                nxt_state = ST_RESET;
        endcase
    end

    assign {o_en_ce, o_en_s, o_en_bm, o_en_acs, o_en_m, o_en_t} = i_en ? en_vec : 6'b000000;

    // traceback only after the trellis has been idle for the whole memory wait
    a_trace_after_wait: assert property (@(posedge clk) disable iff (!rst)
        o_en_t |-> !o_en_ce && $past(!o_en_acs, MEM_WAIT));

endmodule

`default_nettype wire

//--- src/conv_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module conv_encoder (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_en_ce,
    input  logic           i_data,
    output code_pkg::sym_t o_code
);

    import code_pkg::*;

    tstate_t shift_q;  // two previous input bits

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en_ce)
        begin
            shift_q <= '0;
            o_code <= '0;
        end
        else
        begin
            o_code <= encode_sym({i_data, shift_q});
            shift_q <= {i_data, shift_q[1]};
        end
    end

endmodule

`default_nettype wire

//--- src/branch_acs.sv
`timescale 1ns/10ps
`default_nettype none

module branch_acs #(
    parameter int FRAME_LEN = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_en_s,
    input  logic                i_en_bm,
    input  logic                i_en_acs,
    input  code_pkg::sym_t      i_sym,
    output code_pkg::decision_t o_dec,
    output logic                o_dec_valid
);

    import code_pkg::*;

    localparam metric_t METRIC_INIT = 5'd12;  // start states other than 0
    localparam metric_t METRIC_MAX = '1;
    localparam metric_t BM_MAX = 5'd2;
    localparam int CW = $clog2(FRAME_LEN + 1);

    sym_t sym_q;
    logic s_valid;
    logic run_bm;
    logic bm_valid;
    logic pm_init;
    logic pm_ok;
    metric_t bm_q [4];
    metric_t pm [NUM_STATES];
    metric_t cand_even [NUM_STATES];
    metric_t cand_odd [NUM_STATES];
    metric_t pm_sum [NUM_STATES];
    metric_t pm_min;
    decision_t dec_next;
    logic [CW-1:0] dec_cnt;

    function automatic metric_t hamming(sym_t a, sym_t b);
        return metric_t'(a[1] ^ b[1]) + metric_t'(a[0] ^ b[0]);
    endfunction

    assign run_bm = i_en_bm | i_en_acs;  // flush cycle still fills bm stage
    assign pm_init = !i_en_acs && !bm_valid;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            s_valid <= 1'b0;
            bm_valid <= 1'b0;
        end
        else
        begin
            s_valid <= i_en_s;
            bm_valid <= run_bm && s_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_en_s)
            sym_q <= i_sym;  // hard slice
        if (run_bm)
        begin
            for (int c = 0; c < 4; c++)
                bm_q[c] <= hamming(sym_q, sym_t'(c));
        end
        if (bm_valid)
            o_dec <= dec_next;
    end

    always_comb
    begin
        pm_ok = 1'b1;
        for (int s = 0; s < NUM_STATES; s++)
        begin
            cand_even[s] = pm[pred_state(tstate_t'(s), 1'b0)]
                         + bm_q[encode_sym({tstate_t'(s), 1'b0})];
            cand_odd[s] = pm[pred_state(tstate_t'(s), 1'b1)]
                        + bm_q[encode_sym({tstate_t'(s), 1'b1})];
            dec_next[s] = cand_odd[s] < cand_even[s];  // tie keeps even
            pm_sum[s] = dec_next[s] ? cand_odd[s] : cand_even[s];
            if (pm[s] > METRIC_MAX - BM_MAX)
                pm_ok = 1'b0;
        end
        pm_min = pm_sum[0];
        for (int s = 1; s < NUM_STATES; s++)
        begin
            if (pm_sum[s] < pm_min)
                pm_min = pm_sum[s];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst || pm_init)
        begin
            for (int s = 0; s < NUM_STATES; s++)
                pm[s] <= (s == 0) ? metric_t'(0) : METRIC_INIT;
            dec_cnt <= '0;
            o_dec_valid <= 1'b0;
        end
        else if (bm_valid)
        begin
            for (int s = 0; s < NUM_STATES; s++)
                pm[s] <= pm_sum[s] - pm_min;  // renormalize
            o_dec_valid <= dec_cnt < CW'(FRAME_LEN);
            if (dec_cnt < CW'(FRAME_LEN))
                dec_cnt <= dec_cnt + 1'b1;
        end
        else
            o_dec_valid <= 1'b0;
    end

    // path metrics never get close enough to wrap on the next add
    a_pm_bound: assert property (@(posedge clk) disable iff (!rst) pm_ok);

endmodule

`default_nettype wire

//--- src/survivor_mem.sv
`timescale 1ns/10ps
`default_nettype none

module survivor_mem #(
    parameter int FRAME_LEN = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_en_m,
    input  code_pkg::decision_t            i_wr,
    input  logic                           i_wr_valid,
    input  logic [$clog2(FRAME_LEN)-1:0]   i_rd_addr,
    output code_pkg::decision_t            o_rd
);

    import code_pkg::*;

    localparam int AW = $clog2(FRAME_LEN);
    localparam int PW = AW + 1;  // room to count a full frame

    decision_t mem [FRAME_LEN];
    logic [PW-1:0] wr_ptr;
    logic wr_ok;

    assign wr_ok = i_en_m && i_wr_valid && (wr_ptr < PW'(FRAME_LEN));

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en_m)
            wr_ptr <= '0;
        else if (wr_ok)
            wr_ptr <= wr_ptr + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (wr_ok)
            mem[wr_ptr[AW-1:0]] <= i_wr;
        o_rd <= mem[i_rd_addr];
    end

    // the trellis delivers at most one frame of decisions per pass
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst)
        i_en_m && i_wr_valid |-> wr_ptr < PW'(FRAME_LEN));

endmodule

`default_nettype wire

//--- src/traceback.sv
`timescale 1ns/10ps
`default_nettype none

module traceback #(
    parameter int FRAME_LEN = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_en_t,
    input  code_pkg::decision_t            i_rd,
    output logic [$clog2(FRAME_LEN)-1:0]   o_rd_addr,
    output logic [FRAME_LEN-1:0]           o_dec_frame,
    output logic                           o_dec_done
);

    import code_pkg::*;

    localparam int AW = $clog2(FRAME_LEN);

    logic [AW-1:0] rd_addr;
    logic [AW-1:0] rd_pos;   // address of the word now on i_rd
    logic issuing;
    logic rd_pend;
    tstate_t cur_state;
    logic surv_bit;

    assign o_rd_addr = rd_addr;
    assign surv_bit = i_rd[cur_state];

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en_t)
        begin
            rd_addr <= AW'(FRAME_LEN - 1);
            rd_pos <= '0;
            issuing <= 1'b1;
            rd_pend <= 1'b0;
            cur_state <= '0;  // zero tail ends in state 0
            o_dec_frame <= '0;
            o_dec_done <= 1'b0;
        end
        else
        begin
            rd_pend <= issuing;
            rd_pos <= rd_addr;
            if (issuing)
            begin
                if (rd_addr == '0)
                    issuing <= 1'b0;
                else
                    rd_addr <= rd_addr - 1'b1;
            end
            if (rd_pend)
            begin
                o_dec_frame[rd_pos] <= cur_state[K-2];  // newest input bit
                cur_state <= pred_state(cur_state, surv_bit);
            end
            o_dec_done <= rd_pend && (rd_pos == '0);
        end
    end

endmodule

`default_nettype wire

//--- src/viterbi_codec_top.sv
`timescale 1ns/10ps
`default_nettype none

module viterbi_codec_top #(
    parameter int FRAME_LEN = 16,
    parameter int MEM_WAIT = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_en,
    input  ctrl_pkg::mode_t       i_mode,
    input  logic                  i_data,
    input  code_pkg::sym_t        i_sym,
    input  logic                  i_sync,
    output code_pkg::sym_t        o_code,
    output logic [FRAME_LEN-1:0]  o_dec_frame,
    output logic                  o_dec_done
);

    import code_pkg::*;

    logic en_ce;
    logic en_s;
    logic en_bm;
    logic en_acs;
    logic en_m;
    logic en_t;
    decision_t dec_word;
    logic dec_valid;
    decision_t rd_word;
    logic [$clog2(FRAME_LEN)-1:0] rd_addr;

    codec_control #(.MEM_WAIT(MEM_WAIT)) codec_control_i (
        .clk(clk), .rst(rst), .i_en(i_en), .i_mode(i_mode), .i_sync(i_sync),
        .o_en_ce(en_ce), .o_en_s(en_s), .o_en_bm(en_bm),
        .o_en_acs(en_acs), .o_en_m(en_m), .o_en_t(en_t)
    );

    conv_encoder conv_encoder_i (
        .clk(clk), .rst(rst), .i_en_ce(en_ce), .i_data(i_data), .o_code(o_code)
    );

    branch_acs #(.FRAME_LEN(FRAME_LEN)) branch_acs_i (
        .clk(clk), .rst(rst), .i_en_s(en_s), .i_en_bm(en_bm), .i_en_acs(en_acs),
        .i_sym(i_sym), .o_dec(dec_word), .o_dec_valid(dec_valid)
    );

    survivor_mem #(.FRAME_LEN(FRAME_LEN)) survivor_mem_i (
        .clk(clk), .rst(rst), .i_en_m(en_m), .i_wr(dec_word), .i_wr_valid(dec_valid),
        .i_rd_addr(rd_addr), .o_rd(rd_word)
    );

    traceback #(.FRAME_LEN(FRAME_LEN)) traceback_i (
        .clk(clk), .rst(rst), .i_en_t(en_t), .i_rd(rd_word),
        .o_rd_addr(rd_addr), .o_dec_frame(o_dec_frame), .o_dec_done(o_dec_done)
    );

endmodule

`default_nettype wire

//--- dv/tb_viterbi_codec.sv
`timescale 1ns/10ps
`default_nettype none

module tb_viterbi_codec;

    import code_pkg::*;
    import ctrl_pkg::*;

    localparam int FRAME_LEN = 16;
    localparam int MEM_WAIT = 4;
    localparam int NUM_FRAMES = 12;
    localparam int ENC_BITS = 64;
    localparam int DONE_TIMEOUT = 4 * FRAME_LEN + 2 * MEM_WAIT + 20;
    localparam logic [31:0] LFSR_SEED = 32'h2f6b_0cf3;
    localparam logic [31:0] LFSR_TAPS = 32'hb4bc_d35c;  // maximal length, right shift

    logic clk;
    logic rst;
    logic en;
    mode_t mode;
    logic data_bit;
    sym_t sym;
    logic sync;
    sym_t code;
    logic [FRAME_LEN-1:0] dec_frame;
    logic dec_done;

    logic [3*FRAME_LEN-1:0] testdata [NUM_FRAMES];  // {info frame, error mask}
    logic enc_bits [ENC_BITS];
    logic [31:0] lfsr;
    int check_count;
    int err_count;
    int timeout_count;

    viterbi_codec_top #(
        .FRAME_LEN(FRAME_LEN),
        .MEM_WAIT(MEM_WAIT)
    ) viterbi_codec_top_i (
        .clk(clk),
        .rst(rst),
        .i_en(en),
        .i_mode(mode),
        .i_data(data_bit),
        .i_sym(sym),
        .i_sync(sync),
        .o_code(code),
        .o_dec_frame(dec_frame),
        .o_dec_done(dec_done)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        return s >> 1;
    endfunction

    // {g0, g1} from the new bit and the two bits before it
    function automatic logic [1:0] ref_symbol(logic b, logic p1, logic p2);
        return {b ^ p1 ^ p2, b ^ p2};
    endfunction

    // symbol k lands in bits 2k+1 and 2k
    function automatic logic [2*FRAME_LEN-1:0] ref_encode_frame(logic [FRAME_LEN-1:0] info);
        logic [2*FRAME_LEN-1:0] syms;
        logic p1;
        logic p2;
        int k;
        syms = '0;
        p1 = 1'b0;
        p2 = 1'b0;
        for (k = 0; k < FRAME_LEN; k++)
        begin
            syms[2*k +: 2] = ref_symbol(info[k], p1, p2);
            p2 = p1;
            p1 = info[k];
        end
        return syms;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            err_count++;
            $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic check_idle(input string name);
        check_value({name, " o_code"}, 32'd0, 32'(code));
        check_value({name, " o_dec_done"}, 32'd0, 32'(dec_done));
        check_value({name, " o_dec_frame"}, 32'd0, 32'(dec_frame));
    endtask

    task automatic disable_codec(input string name);
        @(posedge clk);
        en <= 1'b0;
        sync <= 1'b0;
        repeat (3)
        begin
            @(posedge clk);
            @(negedge clk);
            check_idle(name);
        end
    endtask

    task automatic run_encode(input int nbits, input string name);
        logic p1;
        logic p2;
        int n;
        for (n = 0; n < nbits; n++)
        begin
            lfsr = lfsr_step(lfsr);
            enc_bits[n] = lfsr[0];
        end
        p1 = 1'b0;
        p2 = 1'b0;
        @(posedge clk);
        en <= 1'b1;
        mode <= ENCODE_MODE;
        @(posedge clk);  // FSM enters ST_ENCODE here
        data_bit <= enc_bits[0];
        for (n = 0; n < nbits; n++)
        begin
            @(posedge clk);
            data_bit <= (n + 1 < nbits) ? enc_bits[n+1] : 1'b0;
            @(negedge clk);
            check_value($sformatf("%s bit %0d", name, n),
                        32'(ref_symbol(enc_bits[n], p1, p2)), 32'(code));
            p2 = p1;
            p1 = enc_bits[n];
        end
    endtask

    task automatic run_decode(input int idx);
        logic [FRAME_LEN-1:0] info;
        logic [2*FRAME_LEN-1:0] rx;
        string name;
        int k;
        int wait_cycles;
        int pulses;
        info = testdata[idx][3*FRAME_LEN-1:2*FRAME_LEN];
        rx = ref_encode_frame(info) ^ testdata[idx][2*FRAME_LEN-1:0];
        name = $sformatf("decode frame %0d", idx);
        @(posedge clk);
        en <= 1'b1;
        mode <= DECODE_MODE;
        @(posedge clk);  // FSM enters ST_SLICE, first symbol due now
        for (k = 0; k < FRAME_LEN; k++)
        begin
            sym <= rx[2*k +: 2];
            sync <= (k == FRAME_LEN - 1);
            @(posedge clk);
        end
        sym <= '0;
        sync <= 1'b0;
        wait_cycles = 0;
        pulses = 0;
        while (pulses == 0 && wait_cycles < DONE_TIMEOUT)
        begin
            @(negedge clk);
            wait_cycles++;
            if (dec_done)
                pulses++;
        end
        if (pulses == 0)
        begin
            timeout_count++;
            $display("%s: decoder never signalled done within %0d cycles", name, DONE_TIMEOUT);
        end
        else
        begin
            for (k = 0; k < FRAME_LEN + MEM_WAIT; k++)
            begin
                @(negedge clk);
                if (dec_done)
                    pulses++;  // a second pulse is an error
            end
            check_value({name, " done pulses"}, 32'd1, 32'(pulses));
            check_value({name, " o_dec_frame"}, 32'(info), 32'(dec_frame));
        end
    endtask

    initial
    begin
        int i;
        clk = 1'b0;
        rst = 1'b0;
        en = 1'b0;
        mode = ENCODE_MODE;
        data_bit = 1'b0;
        sym = '0;
        sync = 1'b0;
        lfsr = LFSR_SEED;
        check_count = 0;
        err_count = 0;
        timeout_count = 0;
        $readmemh("dv/viterbi_testdata.mem", testdata);

        for (i = 0; i < 7; i++)
        begin
            @(negedge clk);
            check_idle("reset");
        end
        @(posedge clk);
        rst <= 1'b1;  // eighth rising edge still sees reset
        repeat (3)
        begin
            @(negedge clk);
            check_idle("idle");
        end

        run_encode(ENC_BITS, "encode");
        disable_codec("after encode");
        for (i = 0; i < NUM_FRAMES; i++)
        begin
            run_decode(i);
            disable_codec($sformatf("after frame %0d", i));
        end
        run_encode(16, "encode after decode");
        disable_codec("end");

        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/viterbi_testdata.mem
// columns: info frame (16 bits, bit 0 sent first, bits 15 and 14 are the zero tail)
// then error mask over the 32 code bits, symbol k in bits 2k+1 and 2k
// clean frames
0000_00000000
3fff_00000000
2a5c_00000000
1b37_00000000
// one flipped bit
2a5c_00000001
1b37_00000200
0f0f_80000000
3c91_00040000
// two flipped bits, six or more symbols apart
2a5c_00002001
1b37_01000020
3fff_40000010
0000_00100004

//--- verilog.f
src/code_pkg.sv
src/ctrl_pkg.sv
src/codec_control.sv
src/conv_encoder.sv
src/branch_acs.sv
src/survivor_mem.sv
src/traceback.sv
src/viterbi_codec_top.sv
dv/tb_viterbi_codec.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_viterbi_codec \
    -f verilog.f -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log && echo "simulation passed" \
    || { echo "no result in sim.log"; exit 1; }
